// ==== scroll_params.svh ====
`ifndef SCROLL_PARAMS_SVH
`define SCROLL_PARAMS_SVH

// system clocks per SPI clock half-period
`define SPI_CLK_DIV 2

// burst sizes in bytes
`define NAME_BURST 32   // one name-table row, 32 tiles
`define ATTR_BURST 8    // one attribute row

// layout of a map image in flash
`define MAP_STRIDE 1024 // bytes per image
`define ATTR_OFFSET 960 // attribute block after 30 name rows

`endif

// ==== scrollPkg.sv ====
`default_nettype none

package scrollPkg;

    // configuration coming from the register side
    typedef struct packed {
        logic        enable;
        logic        pause;
        logic [7:0]  cntMax;    // frames per step minus one
        logic [23:0] flashBase;
        logic [7:0]  mapCount;  // last map index
    } scrollCfg_t;

    typedef struct packed {
        logic [7:0] mapIndex;
        logic [8:0] ptr;
        logic [8:0] ptrDelayed; // pointer before the last step
        logic       scrolling;
    } scrollStatus_t;

    // one row load, name row and optional attribute row
    typedef struct packed {
        logic        needName;
        logic        needAttr;
        logic [23:0] nameFlash;
        logic [23:0] attrFlash;
        logic [8:0]  nameRam;   // word address
        logic [8:0]  attrRam;   // word address
    } loadReq_t;

    typedef struct packed {
        logic [3:0]  en;        // byte enables
        logic [8:0]  addr;
        logic [31:0] data;
    } ramWrite_t;

endpackage

`default_nettype wire

// ==== flashPkg.sv ====
`default_nettype none

package flashPkg;

    // serial flash opcodes, plain read only
    typedef enum logic [7:0] {
        READ = 8'h03
    } flashOp_e;

    typedef enum logic [2:0] {
        SPI_IDLE,
        SPI_CMD,
        SPI_ADDR,
        SPI_DATA,
        SPI_DONE
    } spiState_e;

    // loader FSM
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_NAME,
        LD_ATTR
    } loadState_e;

    // burst read request
    typedef struct packed {
        logic [23:0] addr;
        logic [5:0]  len;   // byte count
    } flashRead_t;

endpackage

`default_nettype wire

// ==== scrollCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scroll_params.svh"

module scrollCtrl (
    input  logic                     clk,
    input  logic                     rst,
    input  scrollPkg::scrollCfg_t    cfg,
    input  logic                     vgaIntr,
    output scrollPkg::scrollStatus_t status,
    output logic                     reqValid,
    output scrollPkg::loadReq_t      req,
    input  logic                     reqReady
);
    import scrollPkg::*;

    logic [2:0]  intrSync;      // two sync flops plus edge history
    logic        framePulse;
    logic [7:0]  divCnt;
    logic [8:0]  ptr;
    logic [8:0]  ptrDelayed;
    logic [7:0]  mapIndex;
    logic        scrolling;
    logic        scrollingQ;
    logic        stall;
    logic        frameOk;
    logic        step;
    logic        stepped;
    logic        needName;
    logic        needAttr;
    logic [23:0] imageBase;
    loadReq_t    reqNext;

    // frame interrupt edge detect
    always_ff @(posedge clk) begin
        if (rst) begin
            intrSync   <= '0;
            framePulse <= 1'b0;
        end else begin
            intrSync   <= {intrSync[1:0], vgaIntr};
            framePulse <= intrSync[1] & ~intrSync[2];
        end
    end

    assign scrolling = cfg.enable && (mapIndex <= cfg.mapCount) && !cfg.pause;

    // no stepping while a load request is pending
    assign stall   = stepped || (reqValid && !reqReady);
    assign frameOk = framePulse && scrolling && !stall;
    assign step    = frameOk && (divCnt == cfg.cntMax);

    // speed divider
    always_ff @(posedge clk) begin
        if (rst || !cfg.enable) begin
            divCnt <= '0;
        end else if (frameOk) begin
            divCnt <= (divCnt >= cfg.cntMax) ? 8'd0 : divCnt + 8'd1;
        end
    end

    // pointer walks down, two pages of 240 rows
    always_ff @(posedge clk) begin
        if (rst || !cfg.enable) begin
            ptr        <= '0;
            ptrDelayed <= '0;
            mapIndex   <= '0;
        end else if (step) begin
            if (ptr == 9'd256) begin
                ptr      <= 9'd239;
                mapIndex <= mapIndex + 8'd1;
            end else if (ptr == 9'd0) begin
                ptr      <= 9'd495;
                mapIndex <= mapIndex + 8'd1;
            end else begin
                ptr <= ptr - 9'd1;
            end
            ptrDelayed <= ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stepped    <= 1'b0;
            scrollingQ <= 1'b0;
        end else begin
            stepped    <= step;
            scrollingQ <= scrolling;
        end
    end

    // load rules on the new pointer
    assign needName = (ptr[2:0] == 3'b111);
    assign needAttr = (ptr[4:0] == 5'b11111) || (ptr == 9'd495) || (ptr == 9'd239);

    assign imageBase = cfg.flashBase + 24'(mapIndex) * 24'(`MAP_STRIDE);

    always_comb begin
        reqNext.needName  = needName;
        reqNext.needAttr  = needAttr;
        reqNext.nameFlash = imageBase + 24'(ptr[7:3]) * 24'(`NAME_BURST);
        reqNext.attrFlash = imageBase + 24'(`ATTR_OFFSET) + 24'(ptr[7:5]) * 24'(`ATTR_BURST);
        reqNext.nameRam   = {ptr[8:3], 3'b000};
        // attribute rows sit after the 240 name words of each page
        reqNext.attrRam   = {ptr[8], 8'd0} + 9'd240 + {5'd0, ptr[7:5], 1'b0};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reqValid <= 1'b0;
        end else if (stepped && (needName || needAttr)) begin
            reqValid <= 1'b1;
        end else if (reqReady) begin
            reqValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stepped && (needName || needAttr)) begin
            req <= reqNext;
        end
    end

    assign status = '{mapIndex: mapIndex, ptr: ptr, ptrDelayed: ptrDelayed,
                      scrolling: scrollingQ};

    ptrLegal: assert property (@(posedge clk) disable iff (rst)
        (ptr <= 9'd239) || (ptr inside {[9'd256:9'd495]}));

    // loader may take its time, request must hold
    reqStable: assert property (@(posedge clk) disable iff (rst)
        reqValid && !reqReady |=> reqValid && $stable(req));

endmodule

`default_nettype wire

// ==== flashToNametable.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scroll_params.svh"

module flashToNametable (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reqValid,
    input  scrollPkg::loadReq_t  req,
    output logic                 reqReady,
    output logic                 rdValid,
    output flashPkg::flashRead_t rd,
    input  logic                 rdReady,
    input  logic                 byteValid,
    input  logic [7:0]           byteData,
    input  logic                 rdDone,
    output scrollPkg::ramWrite_t nameWr,
    output scrollPkg::ramWrite_t attrWr
);
    import scrollPkg::*;
    import flashPkg::*;

    loadState_e  state;
    loadReq_t    reqQ;
    logic [1:0]  byteCnt;   // byte within the word
    logic [3:0]  wordIdx;
    logic [23:0] wordBuf;   // first three bytes of a word
    logic        nameEnQ;
    logic        attrEnQ;
    logic [8:0]  wrAddr;
    logic [31:0] wrData;

    assign reqReady = (state == LD_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= LD_IDLE;
            rdValid <= 1'b0;
        end else begin
            if (rdValid && rdReady) begin
                rdValid <= 1'b0;
            end
            case (state)
                LD_IDLE: begin
                    if (reqValid && req.needName) begin
                        state   <= LD_NAME;
                        rdValid <= 1'b1;
                    end else if (reqValid && req.needAttr) begin
                        state   <= LD_ATTR;
                        rdValid <= 1'b1;
                    end
                end
                LD_NAME: begin
                    if (rdDone && reqQ.needAttr) begin
                        state   <= LD_ATTR;     // attribute row follows
                        rdValid <= 1'b1;
                    end else if (rdDone) begin
                        state <= LD_IDLE;
                    end
                end
                LD_ATTR: begin
                    if (rdDone) begin
                        state <= LD_IDLE;
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    // burst parameters
    always_ff @(posedge clk) begin
        if (state == LD_IDLE && reqValid) begin
            reqQ    <= req;
            rd.addr <= req.needName ? req.nameFlash : req.attrFlash;
            rd.len  <= req.needName ? 6'(`NAME_BURST) : 6'(`ATTR_BURST);
        end else if (state == LD_NAME && rdDone) begin
            rd.addr <= reqQ.attrFlash;
            rd.len  <= 6'(`ATTR_BURST);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            byteCnt <= '0;
            wordIdx <= '0;
            nameEnQ <= 1'b0;
            attrEnQ <= 1'b0;
        end else begin
            nameEnQ <= 1'b0;
            attrEnQ <= 1'b0;
            if (rdValid && rdReady) begin
                byteCnt <= '0;      // new burst
                wordIdx <= '0;
            end else if (byteValid) begin
                byteCnt <= byteCnt + 2'd1;
                if (byteCnt == 2'd3) begin
                    wordIdx <= wordIdx + 4'd1;
                    nameEnQ <= (state == LD_NAME);
                    attrEnQ <= (state == LD_ATTR);
                end
            end
        end
    end

    // little-endian packing, first byte lands in [7:0]
    always_ff @(posedge clk) begin
        if (byteValid) begin
            wordBuf <= {byteData, wordBuf[23:8]};
            if (byteCnt == 2'd3) begin
                wrData <= {byteData, wordBuf};
                wrAddr <= ((state == LD_NAME) ? reqQ.nameRam : reqQ.attrRam) + 9'(wordIdx);
            end
        end
    end

    assign nameWr = '{en: {4{nameEnQ}}, addr: wrAddr, data: wrData};
    assign attrWr = '{en: {4{attrEnQ}}, addr: wrAddr, data: wrData};

    oneWritePort: assert property (@(posedge clk) disable iff (rst)
        !((|nameWr.en) && (|attrWr.en)));

endmodule

`default_nettype wire

// ==== spiFlashReader.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scroll_params.svh"

module spiFlashReader (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdValid,
    input  flashPkg::flashRead_t rd,
    output logic                 rdReady,
    output logic                 byteValid,
    output logic [7:0]           byteData,
    output logic                 rdDone,
    output logic                 spiClk,
    output logic                 spiCs,
    output logic                 spiMosi,
    input  logic                 spiMiso
);
    import flashPkg::*;

    localparam int DivW = $clog2(`SPI_CLK_DIV + 1);

    spiState_e       state;
    logic [DivW-1:0] divCnt;
    logic            active;
    logic            halfTick;  // spiClk toggles here
    logic [31:0]     shiftOut;  // opcode then address
    logic [6:0]      shiftIn;
    logic [4:0]      bitCnt;
    logic [5:0]      bytesLeft;

    assign rdReady  = (state == SPI_IDLE);
    assign active   = (state == SPI_CMD) || (state == SPI_ADDR) || (state == SPI_DATA);
    assign halfTick = active && (divCnt == DivW'(`SPI_CLK_DIV - 1));
    assign spiMosi  = shiftOut[31];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SPI_IDLE;
            divCnt    <= '0;
            spiClk    <= 1'b0;
            spiCs     <= 1'b1;
            bitCnt    <= '0;
            bytesLeft <= '0;
            byteValid <= 1'b0;
            rdDone    <= 1'b0;
        end else begin
            byteValid <= 1'b0;
            rdDone    <= 1'b0;
            divCnt    <= (halfTick || !active) ? '0 : divCnt + 1'b1;
            case (state)
                SPI_IDLE: begin
                    if (rdValid) begin
                        spiCs     <= 1'b0;
                        bitCnt    <= '0;
                        bytesLeft <= rd.len;
                        state     <= SPI_CMD;
                    end
                end
                SPI_CMD, SPI_ADDR, SPI_DATA: begin
                    if (halfTick) begin
                        spiClk <= ~spiClk;
                        if (!spiClk) begin
                            // rising edge, last bit of a byte completes it
                            byteValid <= (state == SPI_DATA) && (bitCnt == 5'd7);
                        end else if (state == SPI_CMD && bitCnt == 5'd7) begin
                            state  <= SPI_ADDR;
                            bitCnt <= '0;
                        end else if (state == SPI_ADDR && bitCnt == 5'd23) begin
                            state  <= SPI_DATA;
                            bitCnt <= '0;
                        end else if (state == SPI_DATA && bitCnt == 5'd7) begin
                            bitCnt    <= '0;
                            bytesLeft <= bytesLeft - 6'd1;
                            if (bytesLeft <= 6'd1) begin
                                state <= SPI_DONE;
                            end
                        end else begin
                            bitCnt <= bitCnt + 5'd1;
                        end
                    end
                end
                SPI_DONE: begin
                    spiCs  <= 1'b1;     // clock is already low here
                    rdDone <= 1'b1;
                    state  <= SPI_IDLE;
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // mode 0 datapath
    always_ff @(posedge clk) begin
        if (state == SPI_IDLE && rdValid) begin
            shiftOut <= {READ, rd.addr};
        end else if (halfTick && spiClk) begin
            shiftOut <= {shiftOut[30:0], 1'b0};    // next bit on falling edge
        end
        if (halfTick && !spiClk) begin
            shiftIn  <= {shiftIn[5:0], spiMiso};
            byteData <= {shiftIn, spiMiso};
        end
    end

    clkIdleLow: assert property (@(posedge clk) disable iff (rst)
        spiCs |-> !spiClk);

endmodule

`default_nettype wire

// ==== scrollTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module scrollTop (
    input  logic                     clk,
    input  logic                     rst,
    input  scrollPkg::scrollCfg_t    cfg,
    input  logic                     vgaIntr,
    input  logic                     spiMiso,
    output scrollPkg::scrollStatus_t status,
    output scrollPkg::ramWrite_t     nameWr,
    output scrollPkg::ramWrite_t     attrWr,
    output logic                     spiClk,
    output logic                     spiCs,
    output logic                     spiMosi
);
    import scrollPkg::*;
    import flashPkg::*;

    // controller to loader
    logic       reqValid;
    logic       reqReady;
    loadReq_t   req;

    // loader to SPI reader
    logic       rdValid;
    logic       rdReady;
    flashRead_t rd;
    logic       byteValid;
    logic [7:0] byteData;
    logic       rdDone;

    scrollCtrl ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .cfg      (cfg),
        .vgaIntr  (vgaIntr),
        .status   (status),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady)
    );

    flashToNametable loader_i (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .req       (req),
        .reqReady  (reqReady),
        .rdValid   (rdValid),
        .rd        (rd),
        .rdReady   (rdReady),
        .byteValid (byteValid),
        .byteData  (byteData),
        .rdDone    (rdDone),
        .nameWr    (nameWr),
        .attrWr    (attrWr)
    );

    spiFlashReader reader_i (
        .clk       (clk),
        .rst       (rst),
        .rdValid   (rdValid),
        .rd        (rd),
        .rdReady   (rdReady),
        .byteValid (byteValid),
        .byteData  (byteData),
        .rdDone    (rdDone),
        .spiClk    (spiClk),
        .spiCs     (spiCs),
        .spiMosi   (spiMosi),
        .spiMiso   (spiMiso)
    );

endmodule

`default_nettype wire

// ==== flashModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module flashModel (
    input  logic spiClk,
    input  logic spiCs,
    input  logic spiMosi,
    output logic spiMiso,
    output logic badOpcode
);
    import flashPkg::*;

    int          bitCount = 0;  // SPI clocks since chip select fell
    logic [7:0]  opcode   = '0;
    logic [23:0] addr     = '0;
    logic        misoQ    = 1'b0;
    logic        badOpQ   = 1'b0;

    assign spiMiso   = misoQ;
    assign badOpcode = badOpQ;

    // contents are a fixed function of the byte address
    function automatic logic [7:0] byteAt(input logic [23:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    // opcode and address shift in on rising edges
    always @(posedge spiClk or negedge spiCs) begin
        if (!spiClk) begin
            bitCount <= 0;      // chip select just fell
        end else if (!spiCs) begin
            if (bitCount < 8) begin
                opcode <= {opcode[6:0], spiMosi};
            end else if (bitCount < 32) begin
                addr <= {addr[22:0], spiMosi};
            end
            if (bitCount == 8 && opcode != READ) begin
                badOpQ <= 1'b1;
            end
            bitCount <= bitCount + 1;
        end
    end

    // read data goes out on falling edges, MSB first
    always @(negedge spiClk) begin
        logic [7:0] dataByte;
        logic [2:0] bitIdx;
        if (!spiCs && bitCount >= 32) begin
            dataByte = byteAt(addr + 24'((bitCount - 32) / 8));
            bitIdx   = 3'(7 - (bitCount - 32) % 8);
            misoQ   <= dataByte[bitIdx];
        end
    end

endmodule

`default_nettype wire

// ==== scrollTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "scroll_params.svh"

module scrollTb;
    import scrollPkg::*;

    localparam int WideFrames     = 24;
    localparam int RestartFrames  = 4;
    localparam int ShortRuns      = 3;
    localparam int MaxShortFrames = 12000;
    localparam int MaxShortGap    = 40;
    // one name burst and one attribute burst plus slack
    localparam int LoadCycles =
        (64 + 8 * (`NAME_BURST + `ATTR_BURST)) * 2 * `SPI_CLK_DIV + 40;
    localparam int MaxWideGap = LoadCycles + 128;
    localparam int CycleLimit = (WideFrames + ShortRuns * RestartFrames) * MaxWideGap
                              + ShortRuns * MaxShortFrames * MaxShortGap
                              + LoadCycles + 4000;

    logic          clk;
    logic          rst;
    scrollCfg_t    cfg;
    logic          vgaIntr;
    logic          spiMiso;
    scrollStatus_t status;
    ramWrite_t     nameWr;
    ramWrite_t     attrWr;
    logic          spiClk;
    logic          spiCs;
    logic          spiMosi;
    logic          badOpcode;

    integer        seed;
    int            cycles;
    logic          followSteps;    // steps taken from status changes in short runs
    logic [8:0]    modelPtr;
    logic [8:0]    modelPrev;
    logic [7:0]    modelMap;
    logic [7:0]    modelDiv;
    ramWrite_t     expWr[$];       // expected RAM writes in order
    logic          expAttr[$];

    scrollTop dut_i (
        .clk(clk), .rst(rst), .cfg(cfg), .vgaIntr(vgaIntr), .spiMiso(spiMiso),
        .status(status), .nameWr(nameWr), .attrWr(attrWr),
        .spiClk(spiClk), .spiCs(spiCs), .spiMosi(spiMosi)
    );

    flashModel flash_i (
        .spiClk(spiClk), .spiCs(spiCs), .spiMosi(spiMosi), .spiMiso(spiMiso),
        .badOpcode(badOpcode)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] flashWord(input logic [23:0] a);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = 8'((a + 24'(k)) ^ ((a + 24'(k)) >> 8));   // low byte xor middle byte
        end
        return w;
    endfunction

    function automatic logic modelScrolling();
        return cfg.enable && (modelMap <= cfg.mapCount) && !cfg.pause;
    endfunction

    function automatic scrollStatus_t expectedStatus(input logic scrolling);
        scrollStatus_t s;
        s.mapIndex   = modelMap;
        s.ptr        = modelPtr;
        s.ptrDelayed = modelPrev;
        s.scrolling  = scrolling;
        return s;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkStatus(input scrollStatus_t exp);
        if (status !== exp) begin
            failRun($sformatf(
                "FAILED status map/ptr/prev/scr got %h %h %h %h expected %h %h %h %h",
                status.mapIndex, status.ptr, status.ptrDelayed, status.scrolling,
                exp.mapIndex, exp.ptr, exp.ptrDelayed, exp.scrolling));
        end
    endtask

    task automatic checkWrite(input ramWrite_t got, input logic [8:0] addr,
                              input logic [31:0] data, input string port);
        if (got.en !== 4'hf)
            failRun($sformatf("FAILED %s.en got %h expected f", port, got.en));
        if (got.addr !== addr)
            failRun($sformatf("FAILED %s.addr got %h expected %h", port, got.addr, addr));
        if (got.data !== data)
            failRun($sformatf("FAILED %s.data got %h expected %h", port, got.data, data));
    endtask

    task automatic queueRow(input logic isAttr, input logic [8:0] ramAddr,
                            input logic [23:0] src, input int words);
        ramWrite_t w;
        for (int i = 0; i < words; i++) begin
            w.en   = 4'hf;
            w.addr = ramAddr + 9'(i);
            w.data = flashWord(src + 24'(4 * i));
            expWr.push_back(w);
            expAttr.push_back(isAttr);
        end
    endtask

    // one pointer step and the row loads it asks for
    task automatic stepModel();
        logic [23:0] image;
        logic [8:0]  attrRow;
        if (modelPtr == 9'd0 || modelPtr == 9'd256) begin
            modelMap = modelMap + 8'd1;
        end
        modelPrev = modelPtr;
        if (modelPtr == 9'd0) modelPtr = 9'd495;
        else if (modelPtr == 9'd256) modelPtr = 9'd239;
        else modelPtr = modelPtr - 9'd1;
        image = cfg.flashBase + 24'(modelMap) * 24'(`MAP_STRIDE);
        if (modelPtr[2:0] == 3'b111) begin
            queueRow(1'b0, {modelPtr[8:3], 3'b000},
                     image + 24'(modelPtr[7:3]) * 24'(`NAME_BURST), `NAME_BURST / 4);
        end
        if (modelPtr[4:0] == 5'b11111 || modelPtr == 9'd495 || modelPtr == 9'd239) begin
            attrRow = (modelPtr[8] ? 9'd256 : 9'd0) + 9'd240 + 9'(modelPtr[7:5]) * 9'd2;
            queueRow(1'b1, attrRow, image + 24'(`ATTR_OFFSET)
                     + 24'(modelPtr[7:5]) * 24'(`ATTR_BURST), `ATTR_BURST / 4);
        end
    endtask

    task automatic takeWrite(input ramWrite_t got, input logic isAttr, input string port);
        if (expWr.size() == 0 || expAttr[0] != isAttr) begin
            failRun($sformatf("a %s write arrived when none was expected", port));
        end else begin
            checkWrite(got, expWr[0].addr, expWr[0].data, port);
            void'(expWr.pop_front());
            void'(expAttr.pop_front());
        end
    endtask

    // all output checks happen once per clock
    task automatic tick();
        @(negedge clk);
        cycles++;
        if (cycles > CycleLimit) failRun("timeout, the run went past its cycle limit");
        if (badOpcode) failRun("the flash saw an opcode other than plain read");
        if (|nameWr.en) takeWrite(nameWr, 1'b0, "nameWr");
        if (|attrWr.en) takeWrite(attrWr, 1'b1, "attrWr");
        if (followSteps && status.ptr !== modelPtr) begin
            if (!modelScrolling()) failRun("the pointer moved while scrolling was off");
            stepModel();
            checkStatus(expectedStatus(1'b1));
        end
    endtask

    task automatic sendFrame(input int gap);
        vgaIntr = 1'b1;
        repeat (2) tick();
        vgaIntr = 1'b0;
        repeat (gap - 2) tick();
    endtask

    // gap longer than any load keeps the divider predictable
    task automatic wideFrame();
        int gap;
        gap = LoadCycles + 64 + int'($unsigned($random(seed)) % 64);
        cfg.pause = ($unsigned($random(seed)) % 4) == 0;    // pause window
        sendFrame(8);
        if (modelScrolling()) begin
            if (modelDiv == cfg.cntMax) begin
                modelDiv = 8'd0;
                stepModel();
            end else begin
                modelDiv = modelDiv + 8'd1;
            end
        end
        checkStatus(expectedStatus(modelScrolling()));
        repeat (gap - 8) tick();
    endtask

    task automatic newConfig();
        cfg.cntMax    = 8'($unsigned($random(seed)) % 4);
        cfg.flashBase = 24'($random(seed));
        cfg.mapCount  = 8'($unsigned($random(seed)) % 3);
        cfg.pause     = 1'b0;
    endtask

    task automatic drainWrites();
        while (expWr.size() != 0) tick();
    endtask

    // disable clears everything before a new setup
    task automatic restartScroll();
        drainWrites();
        cfg.enable = 1'b0;
        repeat (4) tick();
        modelPtr  = '0;
        modelPrev = '0;
        modelMap  = '0;
        modelDiv  = '0;
        checkStatus(expectedStatus(1'b0));
        newConfig();
        cfg.enable = 1'b1;
        tick();
    endtask

    // short gaps let loads hold the pointer back
    task automatic shortRun();
        int frames;
        frames = 0;
        followSteps = 1'b1;
        while (modelScrolling() && frames < MaxShortFrames) begin
            sendFrame(8 + int'($unsigned($random(seed)) % 32));
            frames++;
        end
        if (modelScrolling()) failRun("the scroll did not reach the end of the last map");
        repeat (8) sendFrame(16);  // pointer must stay frozen
        drainWrites();
        followSteps = 1'b0;
        checkStatus(expectedStatus(1'b0));
    endtask

    initial begin
        seed        = 28;
        cycles      = 0;
        followSteps = 1'b0;
        rst         = 1'b1;
        vgaIntr     = 1'b0;
        cfg         = '0;
        modelPtr    = '0;
        modelPrev   = '0;
        modelMap    = '0;
        modelDiv    = '0;
        repeat (5) tick();
        rst = 1'b0;
        tick();
        checkStatus(expectedStatus(1'b0));
        if (spiCs !== 1'b1 || spiClk !== 1'b0) failRun("SPI lines are not idle after reset");
        newConfig();
        cfg.enable = 1'b1;
        repeat (WideFrames) wideFrame();
        cfg.pause = 1'b0;
        repeat (ShortRuns) begin
            restartScroll();
            repeat (RestartFrames) wideFrame();    // divider counts again from zero
            cfg.pause = 1'b0;
            shortRun();
        end
        repeat (LoadCycles) tick();    // no stray writes after the last load
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
scrollPkg.sv
flashPkg.sv
scrollCtrl.sv
flashToNametable.sv
spiFlashReader.sv
scrollTop.sv
flashModel.sv
scrollTb.sv

// ==== Makefile ====
# Verilator build and run of the scroll loader testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module scrollTb -f flist.f -o scrollSim

run: compile
	./obj_dir/scrollSim > sim.log 2>&1; cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
